// ==== test/mm_stim.txt ====
# Columns: W addr data pslverr (write) | R addr data (read, data expected) | P (poll for done)
# addr, data and pslverr in hex; A at 100, B at 200, C at 300, word in bits 6:3, half in bit 2
R 004 00000000
W 128 11112222 0
W 12c 33334444 0
W 248 a5a55a5a 0
W 24c 0123fedc 0
R 128 11112222
R 12c 33334444
R 248 a5a55a5a
R 24c 0123fedc
W 100 00000001 0
W 104 00000000 0
W 108 00010000 0
W 10c 00000000 0
W 110 00000000 0
W 114 00000001 0
W 118 00000000 0
W 11c 00010000 0
W 200 00020001 0
W 204 00040003 0
W 208 00200010 0
W 20c 00400030 0
W 210 02000100 0
W 214 04000300 0
W 218 20001000 0
W 21c 40003000 0
W 000 00000401 0
P
R 004 00000002
R 300 00020001
R 304 00040003
R 308 00200010
R 30c 00400030
R 310 02000100
R 314 04000300
R 318 20001000
R 31c 40003000
W 100 00020001 0
W 104 00040003 0
W 108 00060005 0
W 10c 00080007 0
W 110 000a0009 0
W 114 000c000b 0
W 000 00000301 0
P
R 300 12a20951
R 304 25441bf3
R 308 14c40a62
R 30c 29881f26
R 310 16e60b73
R 314 2dcc2259
R 318 19080c84
R 31c 3210258c
W 100 ffffffff 0
W 104 ffffffff 0
W 108 ffffffff 0
W 10c ffffffff 0
W 110 ffffffff 0
W 114 ffffffff 0
W 118 ffffffff 0
W 11c ffffffff 0
W 000 00001001 0
W 100 12345678 1
P
R 300 ffffffff
R 304 ffffffff
R 318 ffffffff
R 31c ffffffff
R 100 ffffffff
W 300 00000000 1
R 300 ffffffff
W 000 00000001 1
R 004 00000002
R 300 ffffffff

// ==== flist.f ====
rtl/mm_types_pkg.sv
rtl/mm_host_pkg.sv
rtl/mm_pe.sv
rtl/mm_row_ram.sv
rtl/mm_skew_feeder.sv
rtl/mm_systolic_array.sv
rtl/mm_sequencer.sv
rtl/mm_apb_regs.sv
rtl/mm_top.sv
test/tb_mm_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f flist.f --top-module tb_mm_top

if ./obj_dir/Vtb_mm_top | tee /dev/stderr | grep -x "TB PASSED" > /dev/null; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== test/tb_mm_top.sv ====
`timescale 1ns/100ps

module tb_mm_top
  import mm_host_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 8;
  localparam int CYCLES_PER_LINE = 200;
  localparam logic [APB_AW-1:0] STATUS_ADDR = 12'h004;

  logic     clk;
  logic     reset;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  // Parsed stimulus
  logic [7:0]        op_q [$];
  logic [APB_AW-1:0] addr_q [$];
  logic [APB_DW-1:0] data_q [$];
  logic              err_q [$];

  int                fd;
  int                code;
  int                pad;
  int                errors;
  int                checks;
  int                cycles;
  int                limit;
  logic [8*8-1:0]    tok;
  logic [8*120-1:0]  line;
  logic [APB_AW-1:0] f_addr;
  logic [APB_DW-1:0] f_data;
  logic [31:0]       f_err;

  mm_top #(
    .ARRAY_N   (4),
    .DATA_W    (16),
    .MEM_DEPTH (16)
  ) dut0 (
    .clk     (clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // APB host tasks
  ////////////////////////////////////////////////////////////////////////////

  // Setup, access, then hold until pready
  task automatic apb_transfer(input logic wr, input logic [APB_AW-1:0] addr,
                              input logic [APB_DW-1:0] wdata,
                              output logic [APB_DW-1:0] rdata, output logic slverr,
                              output int waits);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    waits = 0;
    #1;
    while (!apb_rsp.pready) begin
      @(negedge clk);
      #1;
      waits++;
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic write_check(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                             input logic exp_err);
    logic [APB_DW-1:0] rd;
    logic              err;
    int                waits;
    apb_transfer(1'b1, addr, data, rd, err, waits);
    checks += 2;
    assert (err == exp_err) else begin
      errors++;
      $display("ERR pslverr on write to %h: got %h, expected %h", addr, err, exp_err);
    end
    assert (waits == 0) else begin
      errors++;
      $display("ERR pready wait states on write to %h: got %h, expected 0", addr, waits);
    end
  endtask

  task automatic read_check(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] exp);
    logic [APB_DW-1:0] rd;
    logic              err;
    int                waits;
    int                exp_waits;
    // Memory reads wait one cycle for the registered RAM
    exp_waits = (addr[REGION_LSB +: 2] == REG_CTRL) ? 0 : 1;
    apb_transfer(1'b0, addr, '0, rd, err, waits);
    checks += 3;
    assert (!err) else begin
      errors++;
      $display("ERR pslverr on read from %h: got %h, expected 0", addr, err);
    end
    assert (waits == exp_waits) else begin
      errors++;
      $display("ERR pready wait states on read from %h: got %h, expected %h",
               addr, waits, exp_waits);
    end
    assert (rd == exp) else begin
      errors++;
      $display("ERR prdata at %h: got %h, expected %h", addr, rd, exp);
    end
  endtask

  // STATUS bit 1 is done
  task automatic wait_done();
    logic [APB_DW-1:0] rd;
    logic              err;
    int                waits;
    rd = '0;
    while (!rd[1]) begin
      apb_transfer(1'b0, STATUS_ADDR, '0, rd, err, waits);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(8031));
    reset   = 1'b1;
    apb_req = '0;
    errors  = 0;
    checks  = 0;

    fd = $fopen("test/mm_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the stimulus file test/mm_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        tok  = '0;
        code = $fscanf(fd, "%s", tok);
        if (code == 1) begin
          if (tok == "#") begin
            code = $fgets(line, fd);
          end else if (tok == "W") begin
            code = $fscanf(fd, "%h %h %h", f_addr, f_data, f_err);
            op_q.push_back("W");
            addr_q.push_back(f_addr);
            data_q.push_back(f_data);
            err_q.push_back(f_err[0]);
          end else if (tok == "R") begin
            code = $fscanf(fd, "%h %h", f_addr, f_data);
            op_q.push_back("R");
            addr_q.push_back(f_addr);
            data_q.push_back(f_data);
            err_q.push_back(1'b0);
          end else if (tok == "P") begin
            op_q.push_back("P");
            addr_q.push_back('0);
            data_q.push_back('0);
            err_q.push_back(1'b0);
          end else begin
            errors++;
            $display("Unknown operation in the stimulus file");
          end
        end
      end
      $fclose(fd);
    end
    // One extra budget line covers reset
    limit = CYCLES_PER_LINE * (op_q.size() + 1);

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int n = 0; n < op_q.size(); n++) begin
      pad = $urandom % 4;
      repeat (pad) @(negedge clk);
      case (op_q[n])
        "W":     write_check(addr_q[n], data_q[n], err_q[n]);
        "R":     read_check(addr_q[n], data_q[n]);
        default: wait_done();
      endcase
    end

    repeat (2) @(negedge clk);
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycles = 0;
    @(posedge clk);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout, the run did not finish within %0d cycles", limit);
    $display("Checks %0d, errors %0d", checks, errors + 1);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== rtl/mm_top.sv ====
`timescale 1ns/100ps

module mm_top
  import mm_types_pkg::*, mm_host_pkg::*;
#(
  parameter int ARRAY_N   = mm_types_pkg::ARRAY_N,
  parameter int DATA_W    = mm_types_pkg::DATA_W,
  parameter int MEM_DEPTH = mm_types_pkg::MEM_DEPTH
) (
  input  logic     clk,
  input  logic     reset,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  logic [ADDR_W-1:0]          host_addr;
  logic [ADDR_W-1:0]          op_addr;
  logic [ADDR_W-1:0]          c_addr;
  logic [ADDR_W-1:0]          addr_ab;
  logic [ADDR_W-1:0]          addr_c;
  row_word_t                  host_wdata;
  row_word_t                  rdata_a;
  row_word_t                  rdata_b;
  row_word_t                  rdata_c;
  row_word_t                  a_edge;
  row_word_t                  b_edge;
  row_word_t                  c_row;
  lane_mask_t                 mask_a;
  lane_mask_t                 mask_b;
  lane_mask_t                 wmask_a;
  lane_mask_t                 wmask_b;
  lane_mask_t                 wmask_c;
  logic                       start;
  logic [KLEN_W-1:0]          k_len;
  logic                       busy;
  logic                       done;
  logic                       op_valid;
  logic                       clear;
  logic                       c_we;
  logic [$clog2(ARRAY_N)-1:0] capture_row;

  mm_apb_regs #(
    .ARRAY_N   (ARRAY_N),
    .DATA_W    (DATA_W),
    .MEM_DEPTH (MEM_DEPTH)
  ) u_regs (
    .clk        (clk),
    .reset      (reset),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .mask_a     (mask_a),
    .mask_b     (mask_b),
    .rdata_a    (rdata_a),
    .rdata_b    (rdata_b),
    .rdata_c    (rdata_c),
    .start      (start),
    .k_len      (k_len),
    .busy       (busy),
    .done       (done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Memory ports, owned by the sequencer while busy
  ////////////////////////////////////////////////////////////////////////////

  assign addr_ab = busy ? op_addr : host_addr;
  assign wmask_a = busy ? '0 : mask_a;
  assign wmask_b = busy ? '0 : mask_b;
  assign addr_c  = busy ? c_addr : host_addr;
  // Whole rows during write-back
  assign wmask_c = (busy && c_we) ? '1 : '0;

  mm_row_ram #(.MEM_DEPTH(MEM_DEPTH), .ARRAY_N(ARRAY_N)) mem_a (
    .clk   (clk),
    .addr  (addr_ab),
    .wdata (host_wdata),
    .wmask (wmask_a),
    .rdata (rdata_a)
  );

  mm_row_ram #(.MEM_DEPTH(MEM_DEPTH), .ARRAY_N(ARRAY_N)) mem_b (
    .clk   (clk),
    .addr  (addr_ab),
    .wdata (host_wdata),
    .wmask (wmask_b),
    .rdata (rdata_b)
  );

  mm_row_ram #(.MEM_DEPTH(MEM_DEPTH), .ARRAY_N(ARRAY_N)) mem_c (
    .clk   (clk),
    .addr  (addr_c),
    .wdata (c_row),
    .wmask (wmask_c),
    .rdata (rdata_c)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Compute path
  ////////////////////////////////////////////////////////////////////////////

  mm_sequencer #(.ARRAY_N(ARRAY_N)) u_seq (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .k_len       (k_len),
    .busy        (busy),
    .done        (done),
    .op_addr     (op_addr),
    .op_valid    (op_valid),
    .clear       (clear),
    .capture_row (capture_row),
    .c_addr      (c_addr),
    .c_we        (c_we)
  );

  mm_skew_feeder #(.ARRAY_N(ARRAY_N)) u_feeder (
    .clk      (clk),
    .reset    (reset),
    .op_valid (op_valid),
    .a_word   (rdata_a),
    .b_word   (rdata_b),
    .a_edge   (a_edge),
    .b_edge   (b_edge)
  );

  mm_systolic_array #(.ARRAY_N(ARRAY_N), .DATA_W(DATA_W)) u_array (
    .clk     (clk),
    .reset   (reset),
    .clear   (clear),
    .a_edge  (a_edge),
    .b_edge  (b_edge),
    .row_sel (capture_row),
    .c_row   (c_row)
  );

endmodule

// ==== rtl/mm_apb_regs.sv ====
`timescale 1ns/100ps

module mm_apb_regs
  import mm_types_pkg::*, mm_host_pkg::*;
#(
  parameter int ARRAY_N   = mm_types_pkg::ARRAY_N,
  parameter int DATA_W    = mm_types_pkg::DATA_W,
  parameter int MEM_DEPTH = mm_types_pkg::MEM_DEPTH
) (
  input  logic              clk,
  input  logic              reset,
  input  apb_req_t          apb_req,
  output apb_rsp_t          apb_rsp,
  output logic [ADDR_W-1:0] host_addr,
  output row_word_t         host_wdata,
  output lane_mask_t        mask_a,
  output lane_mask_t        mask_b,
  input  row_word_t         rdata_a,
  input  row_word_t         rdata_b,
  input  row_word_t         rdata_c,
  output logic              start,
  output logic [KLEN_W-1:0] k_len,
  input  logic              busy,
  input  logic              done
);

  // Lanes carried by one APB beat
  localparam int LANES_PER_BEAT = APB_DW / DATA_W;

  logic              access;
  region_t           region;
  logic              half;
  logic [OFS_W-1:0]  reg_ofs;
  logic [KLEN_W-1:0] wr_klen;
  logic              wr_start;
  logic              is_mem;
  logic              err;
  logic              ctrl_write;
  logic              mem_read;
  logic              rd_wait;
  lane_mask_t        half_mask;
  row_word_t         rd_word;
  logic [APB_DW-1:0] rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  assign access    = apb_req.psel && apb_req.penable;
  assign region    = region_t'(apb_req.paddr[REGION_LSB +: 2]);
  assign half      = apb_req.paddr[HALF_BIT];
  assign reg_ofs   = apb_req.paddr[OFS_W-1:0];
  assign wr_klen   = apb_req.pwdata[CTRL_KLEN_LSB +: KLEN_W];
  assign wr_start  = apb_req.pwdata[CTRL_START_BIT];
  assign is_mem    = (region != REG_CTRL);
  assign host_addr = apb_req.paddr[WORD_LSB +: ADDR_W];

  // Error conditions per region
  always_comb begin
    err = 1'b0;
    case (region)
      MEM_A, MEM_B: err = busy;
      MEM_C:        err = apb_req.pwrite;
      default: begin
        if (reg_ofs == CTRL_OFS) begin
          if (apb_req.pwrite) begin
            err = (wr_start && busy) || (wr_klen == '0) || (int'(wr_klen) > MEM_DEPTH);
          end
        end else if (reg_ofs != STATUS_OFS) begin
          err = 1'b1;
        end
      end
    endcase
  end

  // Spread the beat over every half, the mask picks the real one
  always_comb begin
    for (int l = 0; l < ARRAY_N; l++) begin
      host_wdata.lane[l] = apb_req.pwdata[(l % LANES_PER_BEAT) * DATA_W +: DATA_W];
      half_mask[l]       = ((l / LANES_PER_BEAT) == int'(half));
    end
  end

  assign mask_a = (access && apb_req.pwrite && !err && region == MEM_A) ? half_mask : '0;
  assign mask_b = (access && apb_req.pwrite && !err && region == MEM_B) ? half_mask : '0;

  assign ctrl_write = access && apb_req.pwrite && !err &&
                      (region == REG_CTRL) && (reg_ofs == CTRL_OFS);

  ////////////////////////////////////////////////////////////////////////////
  // Read path and response
  ////////////////////////////////////////////////////////////////////////////

  assign mem_read = access && !apb_req.pwrite && is_mem && !err;

  always_comb begin
    case (region)
      MEM_A:   rd_word = rdata_a;
      MEM_B:   rd_word = rdata_b;
      default: rd_word = rdata_c;
    endcase
  end

  always_comb begin
    rd_data = '0;
    if (is_mem) begin
      for (int l = 0; l < LANES_PER_BEAT; l++) begin
        rd_data[l * DATA_W +: DATA_W] = rd_word.lane[int'(half) * LANES_PER_BEAT + l];
      end
    end else if (reg_ofs == CTRL_OFS) begin
      rd_data[CTRL_KLEN_LSB +: KLEN_W] = k_len;
    end else begin
      rd_data[STATUS_BUSY_BIT] = busy;
      rd_data[STATUS_DONE_BIT] = done;
    end
  end

  // Memory reads hold one extra cycle for the registered RAM output
  assign apb_rsp.pready  = access && (!mem_read || rd_wait);
  assign apb_rsp.pslverr = access && err;
  assign apb_rsp.prdata  = rd_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_wait <= 1'b0;
      start   <= 1'b0;
      k_len   <= '0;
    end else begin
      rd_wait <= mem_read && !rd_wait;
      start   <= ctrl_write && wr_start;
      if (ctrl_write) begin
        k_len <= wr_klen;
      end
    end
  end

  // Completion only in an access phase entered from setup or a stall
  a_pready_access: assert property (@(posedge clk) disable iff (reset)
    apb_rsp.pready |-> access &&
      ($past(apb_req.psel && !apb_req.penable) || $past(access && !apb_rsp.pready)));

  a_start_idle: assert property (@(posedge clk) disable iff (reset)
    start |-> !busy);

endmodule

// ==== rtl/mm_sequencer.sv ====
`timescale 1ns/100ps

module mm_sequencer
  import mm_types_pkg::*;
#(
  parameter int ARRAY_N = mm_types_pkg::ARRAY_N
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  logic [KLEN_W-1:0]          k_len,
  output logic                       busy,
  output logic                       done,
  output logic [ADDR_W-1:0]          op_addr,
  output logic                       op_valid,
  output logic                       clear,
  output logic [$clog2(ARRAY_N)-1:0] capture_row,
  output logic [ADDR_W-1:0]          c_addr,
  output logic                       c_we
);

  // RAM latency, skew, trip across the grid, last accumulate
  localparam int DRAIN_CYC = 1 + (ARRAY_N - 1) + 2 * (ARRAY_N - 1) + 1;

  seq_state_t        state;
  logic [KLEN_W-1:0] cnt;
  logic [KLEN_W-1:0] klen_q;

  assign busy        = (state != IDLE) && (state != DONE);
  assign op_valid    = (state == FEED);
  assign op_addr     = cnt[ADDR_W-1:0];
  assign c_we        = (state == WRITE_BACK);
  assign capture_row = cnt[$clog2(ARRAY_N)-1:0];
  assign c_addr      = cnt[ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= IDLE;
      cnt    <= '0;
      klen_q <= '0;
      clear  <= 1'b0;
      done   <= 1'b0;
    end else begin
      clear <= 1'b0;
      case (state)
        IDLE, DONE: begin
          state <= IDLE;
          if (start) begin
            state  <= FEED;
            cnt    <= '0;
            klen_q <= k_len;
            clear  <= 1'b1;
            done   <= 1'b0;
          end
        end
        FEED: begin
          if (cnt == klen_q - 1'b1) begin
            state <= DRAIN;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        DRAIN: begin
          if (cnt == KLEN_W'(DRAIN_CYC - 1)) begin
            state <= WRITE_BACK;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        WRITE_BACK: begin
          // One C row per cycle
          if (cnt == KLEN_W'(ARRAY_N - 1)) begin
            state <= DONE;
            cnt   <= '0;
            done  <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Register block must have screened k_len before the run
  a_feed_klen: assert property (@(posedge clk) disable iff (reset)
    state == FEED |-> klen_q != '0);

endmodule

// ==== rtl/mm_systolic_array.sv ====
`timescale 1ns/100ps

module mm_systolic_array
  import mm_types_pkg::*;
#(
  parameter int ARRAY_N = mm_types_pkg::ARRAY_N,
  parameter int DATA_W  = mm_types_pkg::DATA_W
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       clear,
  input  row_word_t                  a_edge,
  input  row_word_t                  b_edge,
  input  logic [$clog2(ARRAY_N)-1:0] row_sel,
  output row_word_t                  c_row
);

  // A runs along rows, B runs down columns
  lane_t     a_bus  [ARRAY_N][ARRAY_N+1];
  lane_t     b_bus  [ARRAY_N+1][ARRAY_N];
  row_word_t c_grid [ARRAY_N];

  for (genvar j = 0; j < ARRAY_N; j++) begin : g_top
    assign b_bus[0][j] = b_edge.lane[j];
  end

  ////////////////////////////////////////////////////////////////////////////
  // PE grid
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < ARRAY_N; i++) begin : g_row
    assign a_bus[i][0] = a_edge.lane[i];

    for (genvar j = 0; j < ARRAY_N; j++) begin : g_col
      mm_pe #(
        .DATA_W (DATA_W)
      ) u_pe (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .in_a  (a_bus[i][j]),
        .in_b  (b_bus[i][j]),
        .out_a (a_bus[i][j+1]),
        .out_b (b_bus[i+1][j]),
        .out_c (c_grid[i].lane[j])
      );
    end
  end

  // Result row for write-back
  assign c_row = c_grid[row_sel];

endmodule

// ==== rtl/mm_skew_feeder.sv ====
`timescale 1ns/100ps

module mm_skew_feeder
  import mm_types_pkg::*;
#(
  parameter int ARRAY_N = mm_types_pkg::ARRAY_N
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      op_valid,
  input  row_word_t a_word,
  input  row_word_t b_word,
  output row_word_t a_edge,
  output row_word_t b_edge
);

  // Bit 0 lines up with RAM data, bit i with lane i
  logic [ARRAY_N-1:0] valid_pipe;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[ARRAY_N-2:0], op_valid};
    end
  end

  for (genvar i = 0; i < ARRAY_N; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign a_edge.lane[i] = valid_pipe[i] ? a_word.lane[i] : '0;
      assign b_edge.lane[i] = valid_pipe[i] ? b_word.lane[i] : '0;
    end else begin : g_delay
      lane_t a_line [i];
      lane_t b_line [i];

      // Lane i waits i cycles
      always_ff @(posedge clk) begin
        a_line[0] <= a_word.lane[i];
        b_line[0] <= b_word.lane[i];
        for (int s = 1; s < i; s++) begin
          a_line[s] <= a_line[s-1];
          b_line[s] <= b_line[s-1];
        end
      end

      assign a_edge.lane[i] = valid_pipe[i] ? a_line[i-1] : '0;
      assign b_edge.lane[i] = valid_pipe[i] ? b_line[i-1] : '0;
    end
  end

endmodule

// ==== rtl/mm_row_ram.sv ====
`timescale 1ns/100ps

module mm_row_ram
  import mm_types_pkg::*;
#(
  parameter int MEM_DEPTH = mm_types_pkg::MEM_DEPTH,
  parameter int ARRAY_N   = mm_types_pkg::ARRAY_N
) (
  input  logic              clk,
  input  logic [ADDR_W-1:0] addr,
  input  row_word_t         wdata,
  input  lane_mask_t        wmask,
  output row_word_t         rdata
);

  row_word_t mem [MEM_DEPTH];

  // Lane merge on write, old contents on the read port
  always_ff @(posedge clk) begin
    for (int l = 0; l < ARRAY_N; l++) begin
      if (wmask[l]) begin
        mem[addr].lane[l] <= wdata.lane[l];
      end
    end
    rdata <= mem[addr];
  end

  a_addr_range: assert property (@(posedge clk)
    int'(addr) < MEM_DEPTH);

endmodule

// ==== rtl/mm_pe.sv ====
`timescale 1ns/100ps

module mm_pe
  import mm_types_pkg::*;
#(
  parameter int DATA_W = mm_types_pkg::DATA_W
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  clear,
  input  lane_t in_a,
  input  lane_t in_b,
  output lane_t out_a,
  output lane_t out_b,
  output lane_t out_c
);

  logic [ACC_W-1:0] acc;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc   <= '0;
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
      if (clear) begin
        acc <= '0;
      end else begin
        acc <= acc + ACC_W'(in_a) * ACC_W'(in_b);
      end
    end
  end

  // Clamp to all ones once the sum leaves the lane range
  assign out_c = (|acc[ACC_W-1:DATA_W]) ? '1 : acc[DATA_W-1:0];

endmodule

// ==== rtl/mm_host_pkg.sv ====
package mm_host_pkg;

  localparam int APB_AW = 12;
  localparam int APB_DW = 32;

  // Requester side of the APB link
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  // Completer side
  typedef struct packed {
    logic              pready;
    logic              pslverr;
    logic [APB_DW-1:0] prdata;
  } apb_rsp_t;

  // Address regions, decoded from paddr[9:8]
  typedef enum logic [1:0] {
    REG_CTRL = 2'd0,
    MEM_A    = 2'd1,
    MEM_B    = 2'd2,
    MEM_C    = 2'd3
  } region_t;

  // Field positions inside paddr
  localparam int REGION_LSB = 8;
  localparam int WORD_LSB   = 3;
  localparam int HALF_BIT   = 2;
  localparam int OFS_W      = 8;

  // Register offsets and bit fields
  localparam logic [OFS_W-1:0] CTRL_OFS   = 8'h00;
  localparam logic [OFS_W-1:0] STATUS_OFS = 8'h04;
  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_KLEN_LSB   = 8;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

endpackage

// ==== rtl/mm_types_pkg.sv ====
package mm_types_pkg;

  // Datapath sizing
  localparam int DATA_W    = 16;
  localparam int ARRAY_N   = 4;
  // 32-bit products plus 4 bits of headroom for 16 terms
  localparam int ACC_W     = 36;
  localparam int MEM_DEPTH = 16;
  localparam int ADDR_W    = $clog2(MEM_DEPTH);
  localparam int KLEN_W    = 5;

  // One matrix element
  typedef logic [DATA_W-1:0] lane_t;

  // One memory word, lane 0 sits in the low bits
  typedef struct packed {
    lane_t [ARRAY_N-1:0] lane;
  } row_word_t;

  // Per-lane write enables
  typedef logic [ARRAY_N-1:0] lane_mask_t;

  // Run sequencer states
  typedef enum logic [2:0] {
    IDLE,
    FEED,
    DRAIN,
    WRITE_BACK,
    DONE
  } seq_state_t;

endpackage
